//--- common/fpga_mgmt_pkg.sv
/*
 * Board management shared definitions: PHY extended register table,
 * MDIO frame layout, GPIO widths and timing constants
 */
package fpga_mgmt_pkg;

    // MDIO link to the SGMII PHY
    localparam logic [4:0] PHY_ADDR = 5'd3;
    localparam int MDC_HALF_PERIOD = 4;
    localparam int MDC_PRESC_W = $clog2(MDC_HALF_PERIOD);
    localparam logic [MDC_PRESC_W-1:0] MDC_PRESC_LAST = MDC_PRESC_W'(MDC_HALF_PERIOD - 1);

    // 32 preamble ones followed by a 32 bit frame
    localparam int MDIO_FRAME_BITS = 32;
    localparam int MDIO_BIT_CNT_W = 6;
    localparam logic [MDIO_BIT_CNT_W-1:0] MDIO_PREAMBLE_BITS = 6'd32;
    localparam logic [MDIO_BIT_CNT_W-1:0] MDIO_LAST_BIT = 6'd63;

    localparam logic [1:0] MDIO_START = 2'b01;
    localparam logic [1:0] MDIO_OP_WRITE = 2'b01;
    localparam logic [1:0] MDIO_TA_WRITE = 2'b10;

    // Indirect access to extended registers goes through REGCR and ADDAR
    localparam logic [4:0] REG_REGCR = 5'h0D;
    localparam logic [4:0] REG_ADDAR = 5'h0E;
    localparam logic [15:0] REGCR_ADDR_MODE = 16'h001F;
    localparam logic [15:0] REGCR_DATA_MODE = 16'h401F;

    // CFG4 autoneg timer, SGMIICTL1 clock output, 10M_SGMII_CFG
    localparam int EXT_REG_COUNT = 3;
    localparam logic [15:0] EXT_REG_ADDR [EXT_REG_COUNT] = '{16'h0031, 16'h00D3, 16'h016F};
    localparam logic [15:0] EXT_REG_DATA [EXT_REG_COUNT] = '{16'h0070, 16'h4000, 16'h0015};

    // Four MDIO writes per extended register
    localparam int INIT_STEP_W = 4;
    localparam logic [INIT_STEP_W-1:0] INIT_STEP_COUNT = INIT_STEP_W'(EXT_REG_COUNT * 4);
    localparam int INIT_DELAY_DEFAULT = 'hFFFFF;
    localparam int INIT_DELAY_W = 20;

    // Board GPIO
    localparam int DEBOUNCE_DEPTH = 4;
    localparam int SAMPLE_PERIOD_DEFAULT = 125000;
    localparam int SAMPLE_CNT_W = 17;
    localparam int BTN_COUNT = 5;
    localparam int SW_COUNT = 4;
    localparam int LED_COUNT = 8;
    localparam int GPIO_IN_COUNT = BTN_COUNT + SW_COUNT;

    // Clause-22 frame, sent MSB first
    typedef union packed {
        struct packed {
            logic [1:0]  st;
            logic [1:0]  op;
            logic [4:0]  phy_addr;
            logic [4:0]  reg_addr;
            logic [1:0]  ta;
            logic [15:0] data;
        } f;
        logic [31:0] raw;
    } mdio_frame_u;

endpackage

//--- common/mdio_cmd_if.sv
/*
 * MDIO write command channel, valid/ready handshake
 */
`timescale 1ns/1ps

interface mdio_cmd_if;

    logic [4:0]  reg_addr;
    logic [15:0] data;
    logic        valid;
    // High only while the master is idle
    logic        ready;

    modport requester (
        output reg_addr,
        output data,
        output valid,
        input  ready
    );

    modport responder (
        input  reg_addr,
        input  data,
        input  valid,
        output ready
    );

endinterface

//--- mdio/phy_init_seq.sv
/*
 * PHY bring-up sequencer: waits out a startup delay, then writes the
 * extended register table through REGCR/ADDAR indirect access
 */
`timescale 1ns/1ps

module phy_init_seq #(
    parameter int INIT_DELAY = fpga_mgmt_pkg::INIT_DELAY_DEFAULT
) (
    input  logic          clk_125mhz_int,
    input  logic          rst_125mhz_int,
    mdio_cmd_if.requester cmd,
    output logic          phy_init_done_o
);
    import fpga_mgmt_pkg::*;

    logic [INIT_DELAY_W-1:0] delay_q;
    logic [INIT_STEP_W-1:0]  step_q;
    logic [1:0]              ext_idx;
    logic [4:0]              reg_addr_d;
    logic [15:0]             data_d;
    logic                    delay_done;
    logic                    seq_done;
    logic                    xfer;
    logic                    issue;

    assign delay_done = (delay_q == '0);
    assign seq_done = (step_q == INIT_STEP_COUNT);
    assign xfer = cmd.valid && cmd.ready;
    // New command only once the master is idle again
    assign issue = delay_done && !seq_done && !cmd.valid && cmd.ready;
    assign phy_init_done_o = seq_done;

    // Upper step bits pick the table entry, lower bits the sub-step
    assign ext_idx = step_q[3:2];

    always_comb begin
        case (step_q[1:0])
            2'd0: begin
                reg_addr_d = REG_REGCR;
                data_d = REGCR_ADDR_MODE;
            end
            2'd1: begin
                reg_addr_d = REG_ADDAR;
                data_d = EXT_REG_ADDR[ext_idx];
            end
            2'd2: begin
                reg_addr_d = REG_REGCR;
                data_d = REGCR_DATA_MODE;
            end
            default: begin
                reg_addr_d = REG_ADDAR;
                data_d = EXT_REG_DATA[ext_idx];
            end
        endcase
    end

    always_ff @(posedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            delay_q <= INIT_DELAY_W'(INIT_DELAY);
            step_q <= '0;
            cmd.valid <= 1'b0;
        end else if (!delay_done) begin
            delay_q <= delay_q - 1'b1;
        end else if (xfer) begin
            cmd.valid <= 1'b0;
            step_q <= step_q + 1'b1;
        end else if (issue) begin
            cmd.valid <= 1'b1;
        end
    end

    // Held stable while valid is high
    always_ff @(posedge clk_125mhz_int) begin
        if (issue) begin
            cmd.reg_addr <= reg_addr_d;
            cmd.data <= data_d;
        end
    end

endmodule

//--- mdio/mdio_master.sv
/*
 * Clause-22 MDIO write master: 32 preamble ones, then the frame MSB first,
 * with MDC generated from a half-period prescaler
 */
`timescale 1ns/1ps

module mdio_master (
    input  logic          clk_125mhz_int,
    input  logic          rst_125mhz_int,
    mdio_cmd_if.responder cmd,
    output logic          phy_mdc_o,
    output logic          phy_mdio_o,
    output logic          phy_mdio_oe_o
);
    import fpga_mgmt_pkg::*;

    logic                      busy_q;
    logic [MDC_PRESC_W-1:0]    presc_q;
    logic [MDIO_BIT_CNT_W-1:0] bit_cnt_q;
    logic [MDIO_BIT_CNT_W-1:0] bit_next;
    logic                      accept;
    logic                      half_end;
    logic                      bit_end;
    mdio_frame_u               frame_d;
    mdio_frame_u               frame_q;

    assign cmd.ready = !busy_q;
    assign accept = cmd.valid && !busy_q;
    assign bit_next = bit_cnt_q + 1'b1;

    // MDC half period ends here, a bit ends on the falling edge
    assign half_end = busy_q && (presc_q == MDC_PRESC_LAST);
    assign bit_end = half_end && phy_mdc_o;

    always_comb begin
        frame_d.f.st = MDIO_START;
        frame_d.f.op = MDIO_OP_WRITE;
        frame_d.f.phy_addr = PHY_ADDR;
        frame_d.f.reg_addr = cmd.reg_addr;
        frame_d.f.ta = MDIO_TA_WRITE;
        frame_d.f.data = cmd.data;
    end

    always_ff @(posedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            busy_q <= 1'b0;
            presc_q <= '0;
            bit_cnt_q <= '0;
            phy_mdc_o <= 1'b0;
            phy_mdio_o <= 1'b0;
            phy_mdio_oe_o <= 1'b0;
        end else if (accept) begin
            // First preamble bit goes out right away with MDC low
            busy_q <= 1'b1;
            presc_q <= '0;
            bit_cnt_q <= '0;
            phy_mdc_o <= 1'b0;
            phy_mdio_o <= 1'b1;
            phy_mdio_oe_o <= 1'b1;
        end else if (busy_q) begin
            if (half_end) begin
                presc_q <= '0;
            end else begin
                presc_q <= presc_q + 1'b1;
            end

            if (half_end && !phy_mdc_o) begin
                phy_mdc_o <= 1'b1;
            end

            if (bit_end) begin
                phy_mdc_o <= 1'b0;
                if (bit_cnt_q == MDIO_LAST_BIT) begin
                    busy_q <= 1'b0;
                    phy_mdio_o <= 1'b0;
                    phy_mdio_oe_o <= 1'b0;
                end else begin
                    bit_cnt_q <= bit_next;
                    if (bit_next < MDIO_PREAMBLE_BITS) begin
                        phy_mdio_o <= 1'b1;
                    end else begin
                        phy_mdio_o <= frame_q.raw[MDIO_FRAME_BITS-1];
                    end
                end
            end
        end
    end

    // Frame shifts left once per frame bit sent
    always_ff @(posedge clk_125mhz_int) begin
        if (accept) begin
            frame_q <= frame_d;
        end else if (bit_end && (bit_next >= MDIO_PREAMBLE_BITS)) begin
            frame_q.raw <= {frame_q.raw[MDIO_FRAME_BITS-2:0], 1'b0};
        end
    end

endmodule

//--- hw/board_gpio.sv
/*
 * Button and switch debouncing with LED source selection
 */
`timescale 1ns/1ps

module board_gpio #(
    parameter int SAMPLE_PERIOD = fpga_mgmt_pkg::SAMPLE_PERIOD_DEFAULT
) (
    input  logic                                clk_125mhz_int,
    input  logic                                rst_125mhz_int,
    input  logic [fpga_mgmt_pkg::BTN_COUNT-1:0] btn_i,
    input  logic [fpga_mgmt_pkg::SW_COUNT-1:0]  sw_i,
    input  logic [fpga_mgmt_pkg::LED_COUNT-1:0] block_lock_i,
    input  logic [fpga_mgmt_pkg::LED_COUNT-1:0] core_led_i,
    output logic [fpga_mgmt_pkg::BTN_COUNT-1:0] btn_o,
    output logic [fpga_mgmt_pkg::SW_COUNT-1:0]  sw_o,
    output logic [fpga_mgmt_pkg::LED_COUNT-1:0] led_o
);
    import fpga_mgmt_pkg::*;

    logic [SAMPLE_CNT_W-1:0]   sample_cnt_q;
    logic                      sample_tick;
    logic [GPIO_IN_COUNT-1:0]  raw_in;
    logic [GPIO_IN_COUNT-1:0]  deb_q;
    logic [DEBOUNCE_DEPTH-1:0] hist_q [GPIO_IN_COUNT];

    assign raw_in = {btn_i, sw_i};
    assign {btn_o, sw_o} = deb_q;

    // Raw switch 0 picks the LED source, no debounce on this path
    assign led_o = sw_i[0] ? block_lock_i : core_led_i;

    // First sample is taken right after reset release
    assign sample_tick = (sample_cnt_q == '0);

    always_ff @(posedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            sample_cnt_q <= '0;
        end else if (sample_cnt_q == SAMPLE_CNT_W'(SAMPLE_PERIOD - 1)) begin
            sample_cnt_q <= '0;
        end else begin
            sample_cnt_q <= sample_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            for (int i = 0; i < GPIO_IN_COUNT; i++) begin
                hist_q[i] <= '0;
            end
            deb_q <= '0;
        end else begin
            for (int i = 0; i < GPIO_IN_COUNT; i++) begin
                if (sample_tick) begin
                    hist_q[i] <= {hist_q[i][DEBOUNCE_DEPTH-2:0], raw_in[i]};
                end
                // Output moves only on a unanimous history
                if (&hist_q[i]) begin
                    deb_q[i] <= 1'b1;
                end else if (~|hist_q[i]) begin
                    deb_q[i] <= 1'b0;
                end
            end
        end
    end

endmodule

//--- hw/fpga_mgmt_top.sv
/*
 * Board management top level: PHY bring-up over MDIO and board GPIO
 */
`timescale 1ns/1ps

module fpga_mgmt_top #(
    parameter int INIT_DELAY    = fpga_mgmt_pkg::INIT_DELAY_DEFAULT,
    parameter int SAMPLE_PERIOD = fpga_mgmt_pkg::SAMPLE_PERIOD_DEFAULT
) (
    input  logic                                clk_125mhz_int,
    input  logic                                rst_125mhz_int,
    input  logic [fpga_mgmt_pkg::BTN_COUNT-1:0] btn_i,
    input  logic [fpga_mgmt_pkg::SW_COUNT-1:0]  sw_i,
    input  logic [fpga_mgmt_pkg::LED_COUNT-1:0] block_lock_i,
    input  logic [fpga_mgmt_pkg::LED_COUNT-1:0] core_led_i,
    output logic [fpga_mgmt_pkg::BTN_COUNT-1:0] btn_o,
    output logic [fpga_mgmt_pkg::SW_COUNT-1:0]  sw_o,
    output logic [fpga_mgmt_pkg::LED_COUNT-1:0] led_o,
    output logic                                phy_mdc_o,
    output logic                                phy_mdio_o,
    output logic                                phy_mdio_oe_o,
    output logic                                phy_init_done_o
);

    // Sequencer to MDIO master
    mdio_cmd_if cmd_if ();

    phy_init_seq #(
        .INIT_DELAY (INIT_DELAY)
    ) u_phy_init_seq (
        .clk_125mhz_int  (clk_125mhz_int),
        .rst_125mhz_int  (rst_125mhz_int),
        .cmd             (cmd_if.requester),
        .phy_init_done_o (phy_init_done_o)
    );

    // MDIO tristate buffer lives outside, driven by value and enable
    mdio_master u_mdio_master (
        .clk_125mhz_int (clk_125mhz_int),
        .rst_125mhz_int (rst_125mhz_int),
        .cmd            (cmd_if.responder),
        .phy_mdc_o      (phy_mdc_o),
        .phy_mdio_o     (phy_mdio_o),
        .phy_mdio_oe_o  (phy_mdio_oe_o)
    );

    board_gpio #(
        .SAMPLE_PERIOD (SAMPLE_PERIOD)
    ) u_board_gpio (
        .clk_125mhz_int (clk_125mhz_int),
        .rst_125mhz_int (rst_125mhz_int),
        .btn_i          (btn_i),
        .sw_i           (sw_i),
        .block_lock_i   (block_lock_i),
        .core_led_i     (core_led_i),
        .btn_o          (btn_o),
        .sw_o           (sw_o),
        .led_o          (led_o)
    );

endmodule

//--- sim/mdio_phy_model.sv
/*
 * Testbench PHY: decodes clause-22 MDIO write frames from MDC and MDIO
 */
`timescale 1ns/1ps

module mdio_phy_model (
    input  logic                       mdc_i,
    input  logic                       mdio_i,
    input  logic                       mdio_oe_i,
    output fpga_mgmt_pkg::mdio_frame_u frame_o,
    output int                         frame_cnt_o,
    output int                         preamble_err_o
);
    import fpga_mgmt_pkg::*;

    int          bit_idx;
    mdio_frame_u shift_q;

    initial begin
        bit_idx = 0;
        shift_q = '0;
        frame_o = '0;
        frame_cnt_o = 0;
        preamble_err_o = 0;
    end

    // PHY samples MDIO on the rising MDC edge
    always @(posedge mdc_i) begin
        if (mdio_oe_i) begin
            if (bit_idx < int'(MDIO_PREAMBLE_BITS)) begin
                if (mdio_i !== 1'b1) begin
                    preamble_err_o = preamble_err_o + 1;
                end
            end else begin
                shift_q.raw = {shift_q.raw[MDIO_FRAME_BITS-2:0], mdio_i};
            end

            // 64th bit completes the frame
            if (bit_idx == int'(MDIO_LAST_BIT)) begin
                frame_o = shift_q;
                frame_cnt_o = frame_cnt_o + 1;
                bit_idx = 0;
            end else begin
                bit_idx = bit_idx + 1;
            end
        end
    end

endmodule

//--- sim/tb_fpga_mgmt_top.sv
/*
 * Board management testbench: PHY bring-up frames, completion,
 * debounce and LED selection checked against reference models
 */
`timescale 1ns/1ps

module tb_fpga_mgmt_top;
    import fpga_mgmt_pkg::*;

    localparam int INIT_DELAY = 64;
    localparam int SAMPLE_PERIOD = 16;
    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 10;
    localparam int FRAME_COUNT = EXT_REG_COUNT * 4;
    localparam int QUIET_CYCLES = 2000;
    localparam int HOLD_CYCLES = (DEBOUNCE_DEPTH + 1) * SAMPLE_PERIOD + 1;
    localparam int WATCH_CYCLES = (DEBOUNCE_DEPTH + 1) * SAMPLE_PERIOD;
    localparam int DEB_ROUNDS = 12;
    localparam int LED_CHECKS = 200;
    localparam int MDIO_CYCLES = INIT_DELAY + FRAME_COUNT * 600;
    localparam int GPIO_CYCLES =
        DEB_ROUNDS * (HOLD_CYCLES + SAMPLE_PERIOD + WATCH_CYCLES) + LED_CHECKS;
    // Twice the expected run length
    localparam int WATCHDOG_CYCLES =
        2 * (RESET_CYCLES + MDIO_CYCLES + QUIET_CYCLES + GPIO_CYCLES);

    logic                 clk_125mhz_int = 1'b0;
    logic                 rst_125mhz_int;
    logic [BTN_COUNT-1:0] btn;
    logic [SW_COUNT-1:0]  sw;
    logic [LED_COUNT-1:0] block_lock;
    logic [LED_COUNT-1:0] core_led;
    logic [BTN_COUNT-1:0] btn_deb;
    logic [SW_COUNT-1:0]  sw_deb;
    logic [LED_COUNT-1:0] led;
    logic                 phy_mdc;
    logic                 phy_mdio;
    logic                 phy_mdio_oe;
    logic                 phy_init_done;
    mdio_frame_u          model_frame;
    int                   model_frame_cnt;
    int                   preamble_errors;
    integer               seed;
    int                   error_count = 0;
    int                   tests_run = 0;
    int                   tests_failed = 0;
    int                   frames_seen = 0;
    int                   mdc_edges = 0;
    logic                 mdc_last = 1'b0;

    always #(CLK_PERIOD / 2) clk_125mhz_int = ~clk_125mhz_int;

    fpga_mgmt_top #(
        .INIT_DELAY    (INIT_DELAY),
        .SAMPLE_PERIOD (SAMPLE_PERIOD)
    ) u_dut (
        .clk_125mhz_int  (clk_125mhz_int),
        .rst_125mhz_int  (rst_125mhz_int),
        .btn_i           (btn),
        .sw_i            (sw),
        .block_lock_i    (block_lock),
        .core_led_i      (core_led),
        .btn_o           (btn_deb),
        .sw_o            (sw_deb),
        .led_o           (led),
        .phy_mdc_o       (phy_mdc),
        .phy_mdio_o      (phy_mdio),
        .phy_mdio_oe_o   (phy_mdio_oe),
        .phy_init_done_o (phy_init_done)
    );

    mdio_phy_model u_phy_model (
        .mdc_i          (phy_mdc),
        .mdio_i         (phy_mdio),
        .mdio_oe_i      (phy_mdio_oe),
        .frame_o        (model_frame),
        .frame_cnt_o    (model_frame_cnt),
        .preamble_err_o (preamble_errors)
    );

    task automatic check_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        if (act_val !== exp_val) begin
            $display("ERROR t=%0t %s: expected 0x%0h, got 0x%0h",
                     $time, name, exp_val, act_val);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        tests_run++;
        if (error_count == err_start) begin
            $display("Test %-12s passed", name);
        end else begin
            tests_failed++;
            $display("Test %-12s failed with %0d errors", name, error_count - err_start);
        end
    endtask

    // Write pattern per extended register: REGCR, ADDAR, REGCR, ADDAR
    function automatic logic [4:0] expected_reg_addr(input int n);
        return (n % 2 == 0) ? REG_REGCR : REG_ADDAR;
    endfunction

    function automatic logic [15:0] expected_data(input int n);
        case (n % 4)
            0: return REGCR_ADDR_MODE;
            1: return EXT_REG_ADDR[n / 4];
            2: return REGCR_DATA_MODE;
            default: return EXT_REG_DATA[n / 4];
        endcase
    endfunction

    task automatic check_idle_outputs();
        check_value("phy_mdc_o", 0, 32'(phy_mdc));
        check_value("phy_mdio_oe_o", 0, 32'(phy_mdio_oe));
        check_value("phy_mdio_o", 0, 32'(phy_mdio));
        check_value("phy_init_done_o", 0, 32'(phy_init_done));
        check_value("btn_o", 0, 32'(btn_deb));
        check_value("sw_o", 0, 32'(sw_deb));
    endtask

    task automatic check_frame(input int n, input mdio_frame_u frame);
        check_value($sformatf("frame %0d start", n), 32'(MDIO_START), 32'(frame.f.st));
        check_value($sformatf("frame %0d opcode", n), 32'(MDIO_OP_WRITE), 32'(frame.f.op));
        check_value($sformatf("frame %0d phy_addr", n), 32'(PHY_ADDR), 32'(frame.f.phy_addr));
        check_value($sformatf("frame %0d turnaround", n), 32'(MDIO_TA_WRITE), 32'(frame.f.ta));
        check_value($sformatf("frame %0d reg_addr", n), 32'(expected_reg_addr(n)),
                    32'(frame.f.reg_addr));
        check_value($sformatf("frame %0d data", n), 32'(expected_data(n)), 32'(frame.f.data));
        // Done goes high right after the last command is accepted
        check_value($sformatf("frame %0d phy_init_done_o", n), 32'(n == FRAME_COUNT - 1),
                    32'(phy_init_done));
    endtask

    // Frame and MDC edge monitor, sampled away from the active clock edge
    always @(negedge clk_125mhz_int) begin
        if (model_frame_cnt != frames_seen) begin
            if (frames_seen < FRAME_COUNT) begin
                check_frame(frames_seen, model_frame);
            end
            frames_seen <= frames_seen + 1;
        end
        if (phy_mdc != mdc_last) begin
            mdc_edges <= mdc_edges + 1;
        end
        mdc_last <= phy_mdc;
    end

    task automatic wait_for_frames(input int count, input int limit, output bit timed_out);
        int cycles;
        cycles = 0;
        while (frames_seen < count && cycles < limit) begin
            @(negedge clk_125mhz_int);
            cycles++;
        end
        timed_out = (frames_seen < count);
    endtask

    task automatic run_debounce();
        logic [BTN_COUNT-1:0] btn_val;
        logic [SW_COUNT-1:0]  sw_val;
        int                   glitch_len;
        for (int r = 0; r < DEB_ROUNDS; r++) begin
            btn_val = BTN_COUNT'($random(seed));
            sw_val = SW_COUNT'($random(seed));
            @(negedge clk_125mhz_int);
            btn = btn_val;
            sw = sw_val;
            repeat (HOLD_CYCLES) @(negedge clk_125mhz_int);
            check_value("btn_o", 32'(btn_val), 32'(btn_deb));
            check_value("sw_o", 32'(sw_val), 32'(sw_deb));

            // Glitch shorter than one sample period, caught by at most one sample
            glitch_len = 1 + int'({$random(seed)} % (SAMPLE_PERIOD - 1));
            btn = BTN_COUNT'($random(seed));
            sw = SW_COUNT'($random(seed));
            repeat (glitch_len) begin
                @(negedge clk_125mhz_int);
                check_value("btn_o", 32'(btn_val), 32'(btn_deb));
                check_value("sw_o", 32'(sw_val), 32'(sw_deb));
            end
            btn = btn_val;
            sw = sw_val;
            repeat (WATCH_CYCLES) begin
                @(negedge clk_125mhz_int);
                check_value("btn_o", 32'(btn_val), 32'(btn_deb));
                check_value("sw_o", 32'(sw_val), 32'(sw_deb));
            end
        end
    endtask

    task automatic run_led_select();
        for (int i = 0; i < LED_CHECKS; i++) begin
            @(negedge clk_125mhz_int);
            sw = SW_COUNT'($random(seed));
            block_lock = LED_COUNT'($random(seed));
            core_led = LED_COUNT'($random(seed));
            @(posedge clk_125mhz_int);
            check_value("led_o", 32'(sw[0] ? block_lock : core_led), 32'(led));
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

    initial begin
        int err_start;
        int edges_before;
        int done_low;
        bit timed_out;

        seed = 22556;
        rst_125mhz_int = 1'b1;
        btn = '0;
        sw = '0;
        block_lock = '0;
        core_led = '0;

        err_start = error_count;
        repeat (RESET_CYCLES) begin
            @(negedge clk_125mhz_int);
            check_idle_outputs();
        end
        rst_125mhz_int = 1'b0;
        @(negedge clk_125mhz_int);
        check_idle_outputs();
        report_test("reset_state", err_start);

        err_start = error_count;
        wait_for_frames(FRAME_COUNT, MDIO_CYCLES, timed_out);
        if (timed_out) begin
            $display("MDIO frames: only %0d of %0d frames arrived in time",
                     frames_seen, FRAME_COUNT);
            error_count++;
        end
        check_value("MDIO preamble errors", 0, preamble_errors);
        report_test("mdio_frames", err_start);

        // Let the last bit finish before watching MDC
        err_start = error_count;
        while (phy_mdio_oe) @(negedge clk_125mhz_int);
        @(negedge clk_125mhz_int);
        check_value("phy_init_done_o", 1, 32'(phy_init_done));
        edges_before = mdc_edges;
        done_low = 0;
        repeat (QUIET_CYCLES) begin
            @(negedge clk_125mhz_int);
            if (!phy_init_done) begin
                done_low++;
            end
        end
        check_value("phy_init_done_o low cycles", 0, done_low);
        check_value("phy_mdc_o edges after done", 0, mdc_edges - edges_before);
        check_value("MDIO frame count", FRAME_COUNT, frames_seen);
        report_test("completion", err_start);

        err_start = error_count;
        run_debounce();
        report_test("debounce", err_start);

        err_start = error_count;
        run_led_select();
        report_test("led_select", err_start);

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- fpga_mgmt_top.f
common/fpga_mgmt_pkg.sv
common/mdio_cmd_if.sv
mdio/phy_init_seq.sv
mdio/mdio_master.sv
hw/board_gpio.sv
hw/fpga_mgmt_top.sv
sim/mdio_phy_model.sv
sim/tb_fpga_mgmt_top.sv

//--- Makefile
# Verilator build, run and lint for the board management design

VERILATOR ?= verilator
TOP       ?= tb_fpga_mgmt_top
RTL_TOP   ?= fpga_mgmt_top
FILELIST  ?= fpga_mgmt_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) $(VFLAGS)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Everything OK$$" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
